//--- files.f
+incdir+.
mem_pkg.sv
mem_arbiter.sv
shared_memory.sv
mem_requester.sv
mem_subsystem.sv
mem_subsystem_tb.sv

//--- mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter import mem_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  mem_req_t ireq,
    input  mem_req_t dreq,
    output mem_rsp_t irsp,
    output mem_rsp_t drsp,
    output mem_req_t mreq,
    input  mem_rsp_t mrsp
);

    typedef struct packed {
        access_t  owner;
        mem_req_t grant;
        mem_req_t dpend;
        mem_req_t ipend;
    } arb_state_t;

    localparam arb_state_t arb_init = '{owner: no_access, default: '0};

    arb_state_t r;
    arb_state_t v;

    // ------------------------------
    // next state and bus request
    // ------------------------------
    always_comb begin
        v = r;

        // the bus is free again in the cycle its owner sees ready.
        if (mrsp.ready) begin
            v.owner = no_access;
        end

        if (dreq.valid) begin
            v.dpend = dreq;  // strobes are latched until granted.
        end
        if (ireq.valid) begin
            v.ipend = ireq;
        end

        if (v.owner == no_access) begin
            if (v.dpend.valid) begin
                v.owner = data_access;  // data port first.
                v.grant = v.dpend;
                v.dpend = '0;
            end else if (v.ipend.valid) begin
                v.owner = instr_access;
                v.grant = v.ipend;
                v.ipend = '0;
            end
        end

        if (v.owner != no_access) begin
            mreq = v.grant;  // held as a level until ready.
        end else begin
            mreq = '0;
        end
    end

    // ------------------------------
    // response steering
    // ------------------------------
    always_comb begin
        if (r.owner == instr_access) begin
            irsp = mrsp;
        end else begin
            irsp = '0;
        end

        if (r.owner == data_access) begin
            drsp = mrsp;
        end else begin
            drsp = '0;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            r <= arb_init;
        end else begin
            r <= v;
        end
    end

endmodule

//--- mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// memory geometry.
`define MEM_WORDS 256
`define MEM_INDEX_BITS 8

// cycles from an accepted request to its ready pulse.
`define MEM_LATENCY 3

// address the fetch port holds out of reset.
`define MEM_RESET_ADDR 32'h0000_0000

`endif

//--- mem_pkg.sv
package mem_pkg;

    // ------------------------------
    // bus field types
    // ------------------------------
    typedef logic [31:0] mem_addr_t;  // byte address.
    typedef logic [63:0] mem_data_t;
    typedef logic [7:0]  mem_strb_t;  // all zero means read.

    // ------------------------------
    // request and response
    // ------------------------------
    typedef struct packed {
        logic      valid;
        logic      instr;  // instruction fetch.
        mem_addr_t addr;
        mem_data_t wdata;
        mem_strb_t wstrb;
    } mem_req_t;

    typedef struct packed {
        logic      ready;
        mem_data_t rdata;
    } mem_rsp_t;

    // ------------------------------
    // state machines
    // ------------------------------
    typedef enum logic [1:0] {
        no_access,
        instr_access,
        data_access
    } access_t;

    typedef enum logic {
        mem_idle,
        mem_busy
    } mem_state_t;

endpackage

//--- mem_requester.sv
`timescale 1ns/1ps

`include "mem_config.svh"

module mem_requester import mem_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      start,
    input  mem_req_t  cmd,
    output mem_req_t  req,
    input  mem_rsp_t  rsp,
    output logic      busy,
    output logic      done,
    output mem_data_t rdata
);

    mem_req_t held;
    logic     strobe;
    logic     issue;

    assign issue = start && !busy;  // a start while busy is dropped.

    // ------------------------------
    // command and handshake
    // ------------------------------
    always_ff @(posedge clock) begin
        if (!reset) begin
            held   <= '{addr: `MEM_RESET_ADDR, default: '0};
            strobe <= 1'b0;
            busy   <= 1'b0;
            done   <= 1'b0;
        end else begin
            strobe <= issue;
            done   <= rsp.ready && busy;
            if (issue) begin
                held <= cmd;
                busy <= 1'b1;
            end else if (rsp.ready) begin
                busy <= 1'b0;
            end
        end
    end

    // returned word stays until the next response.
    always_ff @(posedge clock) begin
        if (rsp.ready && busy) begin
            rdata <= rsp.rdata;
        end
    end

    always_comb begin
        req       = held;
        req.valid = strobe;  // one-cycle strobe per command.
    end

endmodule

//--- mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem import mem_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      fetch_start,
    input  mem_req_t  fetch_cmd,
    output logic      fetch_busy,
    output logic      fetch_done,
    output mem_data_t fetch_rdata,
    input  logic      lsu_start,
    input  mem_req_t  lsu_cmd,
    output logic      lsu_busy,
    output logic      lsu_done,
    output mem_data_t lsu_rdata
);

    mem_req_t fetch_req;
    mem_rsp_t fetch_rsp;
    mem_req_t lsu_req;
    mem_rsp_t lsu_rsp;
    mem_req_t bus_req;
    mem_rsp_t bus_rsp;

    // ------------------------------
    // port front ends
    // ------------------------------
    mem_requester fetch_port (
        .clock (clock),
        .reset (reset),
        .start (fetch_start),
        .cmd   (fetch_cmd),
        .req   (fetch_req),
        .rsp   (fetch_rsp),
        .busy  (fetch_busy),
        .done  (fetch_done),
        .rdata (fetch_rdata)
    );

    mem_requester lsu_port (
        .clock (clock),
        .reset (reset),
        .start (lsu_start),
        .cmd   (lsu_cmd),
        .req   (lsu_req),
        .rsp   (lsu_rsp),
        .busy  (lsu_busy),
        .done  (lsu_done),
        .rdata (lsu_rdata)
    );

    // ------------------------------
    // shared bus
    // ------------------------------
    mem_arbiter mem_arbiter_i (
        .clock (clock),
        .reset (reset),
        .ireq  (fetch_req),
        .dreq  (lsu_req),
        .irsp  (fetch_rsp),
        .drsp  (lsu_rsp),
        .mreq  (bus_req),
        .mrsp  (bus_rsp)
    );

    shared_memory shared_memory_i (
        .clock (clock),
        .reset (reset),
        .req   (bus_req),
        .rsp   (bus_rsp)
    );

endmodule

//--- mem_subsystem_check.svh
`ifndef MEM_SUBSYSTEM_CHECK_SVH
`define MEM_SUBSYSTEM_CHECK_SVH

// ------------------------------
// reference model
// ------------------------------
mem_data_t ref_mem [0:`MEM_WORDS-1];

int checks = 0;
int errors = 0;

// returns the stored word, then applies the byte strobes.
function automatic mem_data_t expected_read(input mem_req_t cmd);
    logic [`MEM_INDEX_BITS-1:0] idx;
    mem_data_t                  old;
    idx = cmd.addr[3 +: `MEM_INDEX_BITS];
    old = ref_mem[idx];
    for (int b = 0; b < 8; b++) begin
        if (cmd.wstrb[b]) begin
            ref_mem[idx][8*b +: 8] = cmd.wdata[8*b +: 8];
        end
    end
    return old;
endfunction

// ------------------------------
// comparisons
// ------------------------------
task automatic compare_word(input string name, input mem_data_t actual,
                            input mem_data_t expected);
    checks++;
    if (actual !== expected) begin
        $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
        errors++;
    end
endtask

task automatic check_low(input string name, input logic actual);
    checks++;
    if (actual !== 1'b0) begin
        $display("Mismatch at %0t: %s is %b, expected 0", $time, name, actual);
        errors++;
    end
endtask

task automatic report_error(input string what);
    $display("Error at %0t: %s", $time, what);
    errors++;
endtask

`endif

//--- mem_subsystem_tb.sv
`timescale 1ns/1ps

`include "mem_config.svh"

module mem_subsystem_tb
    import mem_pkg::*;
();

    localparam int pair_count   = 12;  // write and read pairs.
    localparam int fetch_count  = 12;
    localparam int same_count   = 6;
    localparam int random_count = 60;
    localparam int access_count = `MEM_WORDS + 2 * pair_count + fetch_count
                                + 2 * same_count + random_count + 3;
    localparam longint timeout_ns = access_count * (2 * `MEM_LATENCY + 6) * 20 + 2000;
    localparam mem_addr_t addr_mask = mem_addr_t'((`MEM_WORDS - 1) << 3);
    localparam mem_addr_t hot_mask  = 32'h0000_0078;  // 16 words, so accesses collide.

    logic      clock = 1'b0;
    logic      reset;
    logic      fetch_start;
    mem_req_t  fetch_cmd;
    logic      fetch_busy;
    logic      fetch_done;
    mem_data_t fetch_rdata;
    logic      lsu_start;
    mem_req_t  lsu_cmd;
    logic      lsu_busy;
    logic      lsu_done;
    mem_data_t lsu_rdata;

    integer   seed = 32'h8c35;
    logic     filling;
    mem_req_t fetch_q [$];
    mem_req_t lsu_q [$];
    int       fetch_done_count = 0;
    int       lsu_done_count = 0;
    time      fetch_done_time;
    time      lsu_done_time;
    int       tests_run = 0;
    int       tests_failed = 0;

    `include "mem_subsystem_check.svh"

    mem_subsystem mem_subsystem_i (
        .clock       (clock),
        .reset       (reset),
        .fetch_start (fetch_start),
        .fetch_cmd   (fetch_cmd),
        .fetch_busy  (fetch_busy),
        .fetch_done  (fetch_done),
        .fetch_rdata (fetch_rdata),
        .lsu_start   (lsu_start),
        .lsu_cmd     (lsu_cmd),
        .lsu_busy    (lsu_busy),
        .lsu_done    (lsu_done),
        .lsu_rdata   (lsu_rdata)
    );

    always #10 clock = ~clock;

    // ------------------------------
    // stimulus
    // ------------------------------
    function automatic mem_req_t make_cmd(input logic instr, input mem_addr_t addr,
                                          input mem_data_t wdata, input mem_strb_t wstrb);
        mem_req_t cmd;
        cmd = '{valid: 1'b1, instr: instr, addr: addr, wdata: wdata, wstrb: wstrb};
        return cmd;
    endfunction

    // one start pulse on either port, or on both in the same cycle.
    task automatic pulse(input logic do_fetch, input mem_req_t fcmd,
                         input logic do_lsu, input mem_req_t lcmd);
        @(posedge clock);
        if (do_fetch) begin
            fetch_start <= 1'b1;
            fetch_cmd   <= fcmd;
            fetch_q.push_back(fcmd);
        end
        if (do_lsu) begin
            lsu_start <= 1'b1;
            lsu_cmd   <= lcmd;
            lsu_q.push_back(lcmd);
        end
        @(posedge clock);
        fetch_start <= 1'b0;
        lsu_start   <= 1'b0;
    endtask

    task automatic drain();
        @(posedge clock);
        while (fetch_q.size() != 0 || lsu_q.size() != 0) begin
            @(posedge clock);
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    // ------------------------------
    // response checker
    // ------------------------------
    always @(negedge clock) begin : compare_responses
        mem_req_t  cmd;
        mem_data_t exp;
        if (reset && fetch_done) begin
            fetch_done_count++;
            fetch_done_time = $time;
            if (fetch_q.size() == 0) begin
                report_error("fetch_done pulsed with no fetch access outstanding");
            end else begin
                cmd = fetch_q.pop_front();
                exp = expected_read(cmd);  // completion order is grant order.
                if (!filling) begin
                    compare_word("fetch_rdata", fetch_rdata, exp);
                end
            end
        end
        if (reset && lsu_done) begin
            lsu_done_count++;
            lsu_done_time = $time;
            if (lsu_q.size() == 0) begin
                report_error("lsu_done pulsed with no lsu access outstanding");
            end else begin
                cmd = lsu_q.pop_front();
                exp = expected_read(cmd);
                if (!filling) begin
                    compare_word("lsu_rdata", lsu_rdata, exp);
                end
            end
        end
    end

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin : run_tests
        mem_req_t    fcmd;
        mem_req_t    lcmd;
        mem_addr_t   addr;
        int          errors_before;
        int          cycles;
        int          done_before;
        int          issued;
        logic [31:0] coin;
        logic        do_fetch;
        logic        do_lsu;

        reset       = 1'b0;
        fetch_start = 1'b0;
        lsu_start   = 1'b0;
        fetch_cmd   = '0;
        lsu_cmd     = '0;
        filling     = 1'b0;
        repeat (3) @(posedge clock);
        reset <= 1'b1;

        errors_before = errors;
        repeat (4) begin
            @(negedge clock);
            check_low("fetch_busy", fetch_busy);
            check_low("fetch_done", fetch_done);
            check_low("lsu_busy", lsu_busy);
            check_low("lsu_done", lsu_done);
        end
        end_test("reset_idle", errors_before);

        errors_before = errors;
        filling = 1'b1;  // memory holds no known data yet.
        for (int i = 0; i < `MEM_WORDS; i++) begin
            addr = mem_addr_t'(i) << 3;
            pulse(1'b0, '0, 1'b1, make_cmd(1'b0, addr, {addr ^ 32'hc3a5_5a3c, ~addr}, 8'hff));
            drain();
        end
        filling = 1'b0;
        for (int i = 0; i < pair_count; i++) begin
            addr = mem_addr_t'($random(seed)) & addr_mask;
            lcmd = make_cmd(1'b0, addr, {$random(seed), $random(seed)}, mem_strb_t'($random(seed)));
            pulse(1'b0, '0, 1'b1, lcmd);
            drain();
            pulse(1'b0, '0, 1'b1, make_cmd(1'b0, addr, '0, '0));
            drain();
        end
        end_test("lsu_write_read", errors_before);

        errors_before = errors;
        for (int i = 0; i < fetch_count; i++) begin
            addr = mem_addr_t'($random(seed)) & addr_mask;
            pulse(1'b1, make_cmd(1'b1, addr, '0, '0), 1'b0, '0);
            cycles = 0;
            do begin
                @(negedge clock);
                cycles++;
            end while (!fetch_done);
            checks++;
            if (cycles != `MEM_LATENCY + 2) begin
                $display("Mismatch at %0t: fetch_done latency is %0d, expected %0d",
                         $time, cycles, `MEM_LATENCY + 2);
                errors++;
            end
            drain();
        end
        end_test("fetch_alone", errors_before);

        errors_before = errors;
        for (int i = 0; i < same_count; i++) begin
            addr = mem_addr_t'($random(seed)) & addr_mask;
            fcmd = make_cmd(1'b1, addr, '0, '0);
            lcmd = make_cmd(1'b0, addr, {$random(seed), $random(seed)}, mem_strb_t'($random(seed)));
            pulse(1'b1, fcmd, 1'b1, lcmd);
            drain();
            checks++;
            if (lsu_done_time >= fetch_done_time) begin
                report_error("lsu_done did not arrive before fetch_done");
            end
        end
        end_test("same_cycle", errors_before);

        errors_before = errors;
        done_before = fetch_done_count + lsu_done_count;
        issued = 0;
        while (issued < random_count) begin
            @(negedge clock);
            coin     = $random(seed);
            do_fetch = !fetch_busy && coin[0];
            do_lsu   = !lsu_busy && coin[1];
            if (do_fetch || do_lsu) begin
                fcmd = make_cmd(1'b1, mem_addr_t'($random(seed)) & hot_mask, '0, '0);
                lcmd = make_cmd(1'b0, mem_addr_t'($random(seed)) & hot_mask,
                                {$random(seed), $random(seed)},
                                coin[2] ? mem_strb_t'($random(seed)) : '0);
                pulse(do_fetch, fcmd, do_lsu, lcmd);
                issued = issued + do_fetch + do_lsu;
            end
        end
        drain();
        checks++;
        if (fetch_done_count + lsu_done_count - done_before != issued) begin
            report_error("random stream gave a different number of done pulses than starts");
        end
        end_test("random_stream", errors_before);

        errors_before = errors;
        done_before = lsu_done_count;
        addr = mem_addr_t'($random(seed)) & addr_mask;
        pulse(1'b0, '0, 1'b1, make_cmd(1'b0, addr, '0, '0));
        @(negedge clock);
        @(posedge clock);
        lsu_start <= 1'b1;
        lsu_cmd   <= make_cmd(1'b0, addr ^ 32'h8, '1, '1);  // would overwrite a word if taken.
        @(posedge clock);
        lsu_start <= 1'b0;
        drain();
        repeat (`MEM_LATENCY + 4) @(posedge clock);
        checks++;
        if (lsu_done_count - done_before != 1) begin
            report_error("a start while busy changed the number of lsu_done pulses");
        end
        pulse(1'b0, '0, 1'b1, make_cmd(1'b0, addr ^ 32'h8, '0, '0));
        drain();
        end_test("start_while_busy", errors_before);

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(timeout_ns);
        $display("Error: the accesses did not all complete within %0d ns", timeout_ns);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- shared_memory.sv
`timescale 1ns/1ps

`include "mem_config.svh"

module shared_memory import mem_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  mem_req_t req,
    output mem_rsp_t rsp
);

    localparam int count_bits = $clog2(`MEM_LATENCY + 1);

    mem_data_t mem [0:`MEM_WORDS-1];

    mem_state_t              state;
    logic [count_bits-1:0]   count;
    logic [`MEM_INDEX_BITS-1:0] index;
    logic                    accept;
    mem_data_t               rdata_q;

    assign index  = req.addr[3 +: `MEM_INDEX_BITS];
    assign accept = req.valid && (state == mem_idle);  // valid is ignored while busy.

    // ------------------------------
    // latency counter
    // ------------------------------
    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= mem_idle;
            count <= '0;
        end else begin
            case (state)
                mem_idle: begin
                    if (accept) begin
                        state <= mem_busy;
                        count <= count_bits'(`MEM_LATENCY - 1);
                    end
                end
                mem_busy: begin
                    if (count == '0) begin
                        state <= mem_idle;  // ready cycle ends the access.
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                default: begin
                    state <= mem_idle;
                end
            endcase
        end
    end

    // ------------------------------
    // storage
    // ------------------------------
    always_ff @(posedge clock) begin
        if (accept) begin
            rdata_q <= mem[index];  // old word, read before the write lands.
            for (int i = 0; i < 8; i++) begin
                if (req.wstrb[i]) begin
                    mem[index][8*i +: 8] <= req.wdata[8*i +: 8];
                end
            end
        end
    end

    always_comb begin
        rsp.ready = (state == mem_busy) && (count == '0);
        rsp.rdata = rdata_q;
    end

endmodule
